// ==== verilog/fdsu_params.svh ====
/* sizing constants of the fp32 divide / square-root unit
   included by the package and by every module that sizes a port or a counter */
`ifndef FDSU_PARAMS_SVH
`define FDSU_PARAMS_SVH

// ieee 754 single precision layout
`define FDSU_WIDTH     32
`define FDSU_EXP_BITS  8
`define FDSU_MAN_BITS  23
`define FDSU_BIAS      127

// cycles from engine start to engine done
// both engines retire 25 result bits in ITER-1 steps
`define FDSU_ITER      26

// pass-through tag width
`define FDSU_TAG_BITS  4

// canonical quiet nan, returned for every invalid or nan operation
`define FDSU_QNAN      32'h7fc00000

`endif

// ==== verilog/fdsu_pkg.sv ====
/* shared types of the fp32 div/sqrt unit: op codes, FSM states,
   the flag bundle and the request/response structs */
`include "fdsu_params.svh"

package fdsu_pkg;

  // operation select, one bit
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } fdsu_op_e;

  // handshake controller states
  typedef enum logic [1:0] {
    ST_IDLE,  // ready for a new op
    ST_BUSY,  // engine running
    ST_WAIT   // result held for downstream
  } ctrl_state_e;

  // exception flags, same order as the risc-v fflags field
  typedef struct packed {
    logic nv;  // invalid
    logic dz;  // divide by zero
    logic of;  // overflow
    logic uf;  // underflow
    logic nx;  // inexact
  } fp_status_t;

  // operation as presented on the input handshake
  typedef struct packed {
    fdsu_op_e                  op;
    logic [`FDSU_WIDTH-1:0]    a;    // dividend or radicand
    logic [`FDSU_WIDTH-1:0]    b;    // divisor, unused for sqrt
    logic [`FDSU_TAG_BITS-1:0] tag;
  } fp_req_t;

  // controller to mantissa engine
  typedef struct packed {
    logic                     start;    // one cycle pulse
    logic [`FDSU_MAN_BITS:0]  mant_a;   // hidden bit set
    logic [`FDSU_MAN_BITS:0]  mant_b;
    logic                     odd_exp;  // sqrt pre-shift
  } mant_req_t;

  // mantissa engine to controller
  typedef struct packed {
    logic                      done;    // one cycle pulse
    logic [`FDSU_MAN_BITS+1:0] mant;    // truncated result, 25 bits
    logic                      sticky;  // remainder nonzero
  } mant_rsp_t;

endpackage

// ==== verilog/fp32_div_core.sv ====
/* restoring mantissa divider, one quotient bit per cycle
   returns floor(mant_a * 2^24 / mant_b) and a sticky bit FDSU_ITER cycles after start */
`include "fdsu_params.svh"

module fp32_div_core (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  fdsu_pkg::mant_req_t req_i,
  output fdsu_pkg::mant_rsp_t rsp_o
);

  localparam int unsigned cnt_w    = $clog2(`FDSU_ITER);
  localparam int unsigned last_cnt = `FDSU_ITER - 2;  // load edge plus 25 steps

  logic             busy_q;   // loop running
  logic             done_q;
  logic [cnt_w-1:0] cnt_q;    // steps taken
  logic [25:0]      rem_q;    // partial remainder, stays below 2*divisor
  logic [23:0]      dvs_q;    // divisor mantissa
  logic [24:0]      quo_q;    // quotient, new bits enter at the lsb
  logic [25:0]      diff;
  logic             q_bit;

  // ------------------------------------------------------------------
  // step control
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;  // abort, no done for this run
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (req_i.start) begin
          busy_q <= 1'b1;
          cnt_q  <= '0;
        end
      end else if (cnt_q == cnt_w'(last_cnt)) begin
        busy_q <= 1'b0;  // last quotient bit lands this edge
        done_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // shift-subtract datapath
  // ------------------------------------------------------------------
  assign diff  = rem_q - {2'b0, dvs_q};
  assign q_bit = (rem_q >= {2'b0, dvs_q});  // trial subtraction fits

  always_ff @(posedge clk_i) begin
    if (!busy_q && req_i.start) begin
      rem_q <= {2'b0, req_i.mant_a};
      dvs_q <= req_i.mant_b;
      quo_q <= '0;
    end else if (busy_q) begin
      // restore on a failed trial, then bring in the next zero
      rem_q <= (q_bit ? diff : rem_q) << 1;
      quo_q <= {quo_q[23:0], q_bit};
    end
  end

  assign rsp_o.done   = done_q;
  assign rsp_o.mant   = quo_q;
  assign rsp_o.sticky = |rem_q;  // any remainder left means inexact

endmodule

// ==== verilog/fp32_sqrt_core.sv ====
/* digit-by-digit mantissa square root, one root bit per cycle
   radicand is mant_a * 2^24, one more bit up when odd_exp is set */
`include "fdsu_params.svh"

module fp32_sqrt_core (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  fdsu_pkg::mant_req_t req_i,
  output fdsu_pkg::mant_rsp_t rsp_o
);

  localparam int unsigned cnt_w    = $clog2(`FDSU_ITER);
  localparam int unsigned last_cnt = `FDSU_ITER - 2;

  logic             busy_q;
  logic             done_q;
  logic [cnt_w-1:0] cnt_q;
  logic [49:0]      rad_q;    // radicand, consumed two bits per step from the top
  logic [27:0]      rem_q;    // partial remainder, at most 2*root
  logic [24:0]      root_q;
  logic [27:0]      rem_sh;   // remainder with the next bit pair
  logic [27:0]      trial;    // 4*root + 1
  logic             r_bit;

  // ------------------------------------------------------------------
  // step control, same cadence as the divider
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (req_i.start) begin  // start is ignored while running
          busy_q <= 1'b1;
          cnt_q  <= '0;
        end
      end else if (cnt_q == cnt_w'(last_cnt)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // root datapath
  // ------------------------------------------------------------------
  assign rem_sh = {rem_q[25:0], rad_q[49:48]};
  assign trial  = {1'b0, root_q, 2'b01};
  assign r_bit  = (rem_sh >= trial);

  always_ff @(posedge clk_i) begin
    if (!busy_q && req_i.start) begin
      // odd biased exponent means an even true exponent, so shift one more
      rad_q  <= req_i.odd_exp ? {1'b0, req_i.mant_a, 25'b0}
                              : {2'b0, req_i.mant_a, 24'b0};
      rem_q  <= '0;
      root_q <= '0;
    end else if (busy_q) begin
      rad_q  <= rad_q << 2;
      rem_q  <= r_bit ? rem_sh - trial : rem_sh;
      root_q <= {root_q[23:0], r_bit};
    end
  end

  assign rsp_o.done   = done_q;
  assign rsp_o.mant   = root_q;  // msb at bit 24 or 23, controller normalizes
  assign rsp_o.sticky = |rem_q;

endmodule

// ==== verilog/divsqrt_ctrl.sv ====
/* handshake FSM, operand classification, exponent path and result assembly
   starts the engine that fits the op and holds the packed result until handoff */
`include "fdsu_params.svh"

module divsqrt_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  input  logic                      in_valid_i,
  input  logic                      out_ready_i,
  input  fdsu_pkg::fp_req_t         req_i,
  output logic                      in_ready_o,
  output logic                      out_valid_o,
  output logic                      busy_o,
  output logic [`FDSU_WIDTH-1:0]    result_o,
  output fdsu_pkg::fp_status_t      status_o,
  output logic [`FDSU_TAG_BITS-1:0] tag_o,
  output fdsu_pkg::mant_req_t       div_req_o,
  output fdsu_pkg::mant_req_t       sqrt_req_o,
  input  fdsu_pkg::mant_rsp_t       div_rsp_i,
  input  fdsu_pkg::mant_rsp_t       sqrt_rsp_i
);
  import fdsu_pkg::*;

  localparam logic signed [9:0]         bias    = `FDSU_BIAS;
  localparam logic [`FDSU_WIDTH-2:0]    inf_mag = {{`FDSU_EXP_BITS{1'b1}},
                                                   {`FDSU_MAN_BITS{1'b0}}};

  ctrl_state_e                state_q, state_d;
  fp_req_t                    req_q;               // latched operands and tag
  logic                       accept;              // input handshake this cycle
  logic                       accept_q, start_q;   // start goes out one edge late
  mant_rsp_t                  eng_rsp;             // response of the selected engine
  logic [`FDSU_EXP_BITS-1:0]  exp_a, exp_b;
  logic                       zero_a, inf_a, nan_a, snan_a;
  logic                       zero_b, inf_b, nan_b, snan_b;
  logic                       is_div, sign_r;
  logic                       special;
  logic [`FDSU_WIDTH-1:0]     spec_res;
  fp_status_t                 spec_sts;
  logic signed [9:0]          exp_base, exp_fin;   // biased, before range check
  logic                       hi;                  // engine msb at bit 24
  logic [`FDSU_MAN_BITS-1:0]  frac;
  logic [`FDSU_WIDTH-1:0]     res_d, result_q;
  fp_status_t                 sts_d, status_q;
  logic [`FDSU_TAG_BITS-1:0]  tag_q;

  // ------------------------------------------------------------------
  // handshake FSM
  // ------------------------------------------------------------------
  assign in_ready_o  = (state_q == ST_IDLE);  // no accept during handoff
  assign out_valid_o = (state_q == ST_WAIT);
  assign busy_o      = (state_q != ST_IDLE);
  assign accept      = in_valid_i & in_ready_o & ~flush_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: if (accept) state_d = ST_BUSY;
      ST_BUSY: if (eng_rsp.done) state_d = ST_WAIT;  // result goes to hold reg
      ST_WAIT: if (out_ready_i) state_d = ST_IDLE;   // handoff
      default: state_d = ST_IDLE;
    endcase
    if (flush_i) state_d = ST_IDLE;  // flush wins over everything
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      accept_q <= 1'b0;
      start_q  <= 1'b0;
    end else begin
      state_q  <= state_d;
      accept_q <= accept;
      start_q  <= accept_q & ~flush_i;
    end
  end

  // ------------------------------------------------------------------
  // engine requests, both see the operands, one gets the start
  // ------------------------------------------------------------------
  assign is_div = (req_q.op == OP_DIV);

  assign div_req_o.start    = start_q & is_div;
  assign div_req_o.mant_a   = {1'b1, req_q.a[`FDSU_MAN_BITS-1:0]};
  assign div_req_o.mant_b   = {1'b1, req_q.b[`FDSU_MAN_BITS-1:0]};
  assign div_req_o.odd_exp  = exp_a[0];
  assign sqrt_req_o.start   = start_q & ~is_div;
  assign sqrt_req_o.mant_a  = {1'b1, req_q.a[`FDSU_MAN_BITS-1:0]};
  assign sqrt_req_o.mant_b  = {1'b1, req_q.b[`FDSU_MAN_BITS-1:0]};
  assign sqrt_req_o.odd_exp = exp_a[0];  // biased lsb set, true exponent even

  assign eng_rsp = is_div ? div_rsp_i : sqrt_rsp_i;

  // ------------------------------------------------------------------
  // operand classes, subnormals count as zero
  // ------------------------------------------------------------------
  assign exp_a  = req_q.a[`FDSU_WIDTH-2:`FDSU_MAN_BITS];
  assign exp_b  = req_q.b[`FDSU_WIDTH-2:`FDSU_MAN_BITS];
  assign zero_a = (exp_a == '0);
  assign zero_b = (exp_b == '0);
  assign inf_a  = (&exp_a) & (req_q.a[`FDSU_MAN_BITS-1:0] == '0);
  assign inf_b  = (&exp_b) & (req_q.b[`FDSU_MAN_BITS-1:0] == '0);
  assign nan_a  = (&exp_a) & (req_q.a[`FDSU_MAN_BITS-1:0] != '0);
  assign nan_b  = (&exp_b) & (req_q.b[`FDSU_MAN_BITS-1:0] != '0);
  assign snan_a = nan_a & ~req_q.a[`FDSU_MAN_BITS-1];  // quiet bit clear
  assign snan_b = nan_b & ~req_q.b[`FDSU_MAN_BITS-1];
  assign sign_r = is_div ? req_q.a[`FDSU_WIDTH-1] ^ req_q.b[`FDSU_WIDTH-1]
                         : req_q.a[`FDSU_WIDTH-1];

  always_comb begin : special_case
    special  = 1'b1;
    spec_res = `FDSU_QNAN;  // default for every invalid case
    spec_sts = '0;
    if (is_div) begin
      if (nan_a | nan_b) spec_sts.nv = snan_a | snan_b;
      else if ((zero_a & zero_b) | (inf_a & inf_b)) spec_sts.nv = 1'b1;
      else if (inf_a) spec_res = {sign_r, inf_mag};
      else if (zero_b) begin
        spec_res    = {sign_r, inf_mag};  // finite nonzero over zero
        spec_sts.dz = 1'b1;
      end
      else if (inf_b | zero_a) spec_res = {sign_r, {(`FDSU_WIDTH-1){1'b0}}};
      else special = 1'b0;
    end else begin
      if (nan_a) spec_sts.nv = snan_a;
      else if (zero_a) spec_res = {sign_r, {(`FDSU_WIDTH-1){1'b0}}};  // sqrt(-0) is -0
      else if (sign_r) spec_sts.nv = 1'b1;                           // negative operand
      else if (inf_a) spec_res = {1'b0, inf_mag};
      else special = 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // exponent path and result assembly
  // ------------------------------------------------------------------
  always_comb begin : assemble
    if (is_div) exp_base = $signed({2'b0, exp_a}) - $signed({2'b0, exp_b}) + bias;
    else exp_base = (($signed({2'b0, exp_a}) - bias) >>> 1) + bias;  // floor halving
    hi      = eng_rsp.mant[`FDSU_MAN_BITS+1];
    exp_fin = exp_base;
    if (is_div && !hi) exp_fin = exp_base - 10'sd1;  // quotient below one
    frac     = hi ? eng_rsp.mant[`FDSU_MAN_BITS:1] : eng_rsp.mant[`FDSU_MAN_BITS-1:0];
    sts_d    = '0;
    sts_d.nx = (hi & eng_rsp.mant[0]) | eng_rsp.sticky;  // dropped bit or remainder
    res_d    = {sign_r, exp_fin[`FDSU_EXP_BITS-1:0], frac};
    if (exp_fin >= 10'sd255) begin
      res_d    = {sign_r, inf_mag};
      sts_d.of = 1'b1;
      sts_d.nx = 1'b1;
    end else if (exp_fin <= 10'sd0) begin
      res_d    = {sign_r, {(`FDSU_WIDTH-1){1'b0}}};  // no subnormal results
      sts_d.uf = 1'b1;
      sts_d.nx = 1'b1;
    end
    if (special) begin
      res_d = spec_res;
      sts_d = spec_sts;
    end
  end

  // operand latch and hold register
  always_ff @(posedge clk_i) begin
    if (accept) req_q <= req_i;
    if (state_q == ST_BUSY && eng_rsp.done) begin
      result_q <= res_d;
      status_q <= sts_d;
      tag_q    <= req_q.tag;
    end
  end

  assign result_o = result_q;
  assign status_o = status_q;
  assign tag_o    = tag_q;

endmodule

// ==== verilog/fdsu_lite_top.sv ====
/* fp32 divide and square-root unit, one operation in flight
   valid/ready on both sides, flush aborts the running operation */
`include "fdsu_params.svh"

module fdsu_lite_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // input handshake
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  fdsu_pkg::fp_req_t         req_i,
  // output handshake
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [`FDSU_WIDTH-1:0]    result_o,
  output fdsu_pkg::fp_status_t      status_o,
  output logic [`FDSU_TAG_BITS-1:0] tag_o,
  output logic                      busy_o       // op accepted, not yet handed off
);
  import fdsu_pkg::*;

  mant_req_t div_req, sqrt_req;  // controller to engines
  mant_rsp_t div_rsp, sqrt_rsp;  // engines back to controller

  divsqrt_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .out_ready_i (out_ready_i),
    .req_i       (req_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .div_req_o   (div_req),
    .sqrt_req_o  (sqrt_req),
    .div_rsp_i   (div_rsp),
    .sqrt_rsp_i  (sqrt_rsp)
  );

  // engines sit side by side, only one is started per op
  fp32_div_core i_div (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .req_i   (div_req),
    .rsp_o   (div_rsp)
  );

  fp32_sqrt_core i_sqrt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .req_i   (sqrt_req),
    .rsp_o   (sqrt_rsp)
  );

endmodule

// ==== sim/fdsu_lite_checker.sv ====
/* protocol checks on the fp32 div/sqrt top level
   bound into every fdsu_lite_top instance */
`include "fdsu_params.svh"

module fdsu_lite_checker (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      flush_i,
  input logic                      in_ready_o,
  input logic                      out_valid_o,
  input logic                      out_ready_i,
  input logic                      busy_o,
  input logic [`FDSU_WIDTH-1:0]    result_o,
  input logic [4:0]                status_o,
  input logic [`FDSU_TAG_BITS-1:0] tag_o
);

  // held result must not move while downstream stalls
  hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=>
      (out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o)))
    else $error("output changed under back-pressure");

  // one op in flight until its handoff or a flush
  no_ready_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (busy_o && !flush_i && !(out_valid_o && out_ready_i)) |=> (busy_o && !in_ready_o))
    else $error("in_ready_o rose before the handoff");

  flush_kills_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_o)
    else $error("out_valid_o high after flush");

endmodule

bind fdsu_lite_top fdsu_lite_checker i_checker (.*);

// ==== sim/fdsu_lite_tb.sv ====
/* drives random and directed ops, back-pressure and flush into the fp32 div/sqrt unit
   and checks every result against an integer reference model */
`include "fdsu_params.svh"

module fdsu_lite_tb;
  import fdsu_pkg::*;

  localparam int n_ops   = 140;  // upper bound of issued ops
  localparam int limit   = n_ops * (`FDSU_ITER + 10) * 10 + 2000;

  logic                      clk_i = 1'b0;
  logic                      rst_n_i, flush_i, in_valid_i, out_ready_i;
  fp_req_t                   req_i;
  logic                      in_ready_o, out_valid_o, busy_o;
  logic [`FDSU_WIDTH-1:0]    result_o;
  fp_status_t                status_o;
  logic [`FDSU_TAG_BITS-1:0] tag_o;

  logic [40:0]               exp_q[$];     // {tag, result, status}
  logic [`FDSU_TAG_BITS-1:0] tag_cnt = '0;
  int                        errors = 0;
  int                        cyc = 0, acc_cyc = 0;
  logic                      vld_prev = 1'b0;
  bit                        bp_en = 1'b0;  // random stall on out_ready_i

  always #5 clk_i = ~clk_i;

  fdsu_lite_top i_fdsu_lite_top (.*);

  // ------------------------------------------------------------------
  // reference model in integer arithmetic on the ieee fields
  // ------------------------------------------------------------------
  function automatic logic [36:0] ref_divsqrt(input logic op, input logic [31:0] a,
                                              input logic [31:0] b);
    logic [7:0]      ea, eb;
    logic            sa, sb, s, hi;
    logic            za, zb, ia, ib, na, nb, sna, snb;
    longint unsigned ma, mb, num, q, r, rad, t;
    int              e;
    ea  = a[30:23];
    eb  = b[30:23];
    sa  = a[31];
    sb  = b[31];
    za  = (ea == 8'h00);              // subnormal counts as zero
    zb  = (eb == 8'h00);
    ia  = (ea == 8'hff) && (a[22:0] == 0);
    ib  = (eb == 8'hff) && (b[22:0] == 0);
    na  = (ea == 8'hff) && (a[22:0] != 0);
    nb  = (eb == 8'hff) && (b[22:0] != 0);
    sna = na && !a[22];
    snb = nb && !b[22];
    ma  = {40'd1, a[22:0]};
    mb  = {40'd1, b[22:0]};
    if (op == 1'b0) begin
      s = sa ^ sb;
      if (na || nb) return {`FDSU_QNAN, sna | snb, 4'b0};
      if ((za && zb) || (ia && ib)) return {`FDSU_QNAN, 5'b10000};
      if (ia) return {s, 8'hff, 23'd0, 5'b00000};
      if (zb) return {s, 8'hff, 23'd0, 5'b01000};  // divide by zero
      if (ib || za) return {s, 31'd0, 5'b00000};
      num = ma << 24;
      q   = num / mb;
      r   = num % mb;
      hi  = q[24];
      e   = int'(ea) - int'(eb) + `FDSU_BIAS - (hi ? 0 : 1);
    end else begin
      s = 1'b0;
      if (na) return {`FDSU_QNAN, sna, 4'b0};
      if (za) return {sa, 31'd0, 5'b00000};       // sqrt(-0) keeps the sign
      if (sa) return {`FDSU_QNAN, 5'b10000};
      if (ia) return {32'h7f800000, 5'b00000};
      rad = ma << (ea[0] ? 25 : 24);              // even true exponent gets one more bit
      q   = 0;
      for (int k = 24; k >= 0; k--) begin
        t = q | (64'd1 << k);
        if (t * t <= rad) q = t;
      end
      r  = rad - q * q;
      hi = q[24];
      e  = ((int'(ea) - `FDSU_BIAS) >>> 1) + `FDSU_BIAS;
    end
    if (e >= 255) return {s, 8'hff, 23'd0, 5'b00101};
    if (e <= 0) return {s, 31'd0, 5'b00011};
    return {s, e[7:0], (hi ? q[23:1] : q[22:0]), 4'b0, (hi & q[0]) | (r != 0)};
  endfunction

  // ------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------
  task automatic issue(input logic op, input logic [31:0] a, input logic [31:0] b,
                       input bit keep);
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    req_i.op   = fdsu_op_e'(op);
    req_i.a    = a;
    req_i.b    = b;
    req_i.tag  = tag_cnt;
    in_valid_i = 1'b1;
    if (keep) exp_q.push_back({tag_cnt, ref_divsqrt(op, a, b)});
    tag_cnt++;
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  function automatic logic [31:0] rand_normal(input logic sign);
    logic [7:0] e;
    e = 8'($urandom_range(254, 1));
    return {sign, e, 23'($urandom)};
  endfunction

  // out_ready_i stalls only when back-pressure is enabled
  always @(negedge clk_i) out_ready_i <= bp_en ? 1'($urandom) : 1'b1;

  // ------------------------------------------------------------------
  // comparison and latency check
  // ------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [40:0] e;
    cyc = cyc + 1;
    if (rst_n_i) begin
      if (in_valid_i && in_ready_o && !flush_i) acc_cyc = cyc;
      if (out_valid_o && !vld_prev)
        assert (cyc - 1 - acc_cyc == `FDSU_ITER + 2)
        else begin
          $display("latency wrong: result %0d cycles after accept", cyc - 1 - acc_cyc);
          errors++;
        end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("result handed off with no operation outstanding");
          errors++;
        end else begin
          e = exp_q.pop_front();
          assert (result_o == e[36:5])
          else begin
            $display("Fail result_o: got %h exp %h", result_o, e[36:5]);
            errors++;
          end
          assert (status_o == e[4:0])
          else begin
            $display("Fail status_o: got %h exp %h", status_o, e[4:0]);
            errors++;
          end
          assert (tag_o == e[40:37])
          else begin
            $display("Fail tag_o: got %h exp %h", tag_o, e[40:37]);
            errors++;
          end
        end
      end
    end
    vld_prev = out_valid_o;
  end

  // watchdog
  initial begin
    #(limit);
    $display("watchdog expired, the unit stopped responding");
    $display("TEST FAIL");
    $finish;
  end

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(32'h05f5_a3b3));
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    req_i       = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // random normal divisions without stalls
    for (int i = 0; i < 40; i++)
      issue(1'b0, rand_normal(1'($urandom)), rand_normal(1'($urandom)), 1'b1);
    // square roots of positive normals with both exponent parities
    for (int i = 0; i < 30; i++) issue(1'b1, rand_normal(1'b0), 32'h0, 1'b1);
    issue(1'b1, 32'h40800000, 32'h0, 1'b1);  // sqrt(4)
    issue(1'b1, 32'h40000000, 32'h0, 1'b1);  // sqrt(2)

    // directed special cases
    issue(1'b0, 32'h00000000, 32'h80000000, 1'b1);  // 0/0
    issue(1'b0, 32'h7f800000, 32'hff800000, 1'b1);  // inf/inf
    issue(1'b0, 32'h3f800000, 32'h00000000, 1'b1);  // 1/0
    issue(1'b0, 32'hbf800000, 32'h00000000, 1'b1);  // -1/0
    issue(1'b0, 32'h7f800000, 32'h40000000, 1'b1);
    issue(1'b0, 32'h40000000, 32'hff800000, 1'b1);
    issue(1'b0, 32'h00000000, 32'h40400000, 1'b1);
    issue(1'b0, 32'h7f800001, 32'h3f800000, 1'b1);  // signaling nan
    issue(1'b0, 32'h7fc00001, 32'h3f800000, 1'b1);  // quiet nan
    issue(1'b0, 32'h3f800000, 32'hffa00000, 1'b1);
    issue(1'b0, 32'h7f000000, 32'h3e800000, 1'b1);  // overflow
    issue(1'b0, 32'h00800000, 32'h7f000000, 1'b1);  // underflow
    issue(1'b0, 32'h40400000, 32'h3f800000, 1'b1);  // exact 3
    issue(1'b0, 32'h3f800000, 32'h40400000, 1'b1);  // inexact third
    issue(1'b1, 32'h00000000, 32'h0, 1'b1);         // sqrt(+0)
    issue(1'b1, 32'h80000000, 32'h0, 1'b1);         // sqrt(-0)
    issue(1'b1, 32'h7f800000, 32'h0, 1'b1);
    issue(1'b1, 32'hc0800000, 32'h0, 1'b1);         // negative operand
    issue(1'b1, 32'hff800001, 32'h0, 1'b1);
    issue(1'b1, 32'h7fc00000, 32'h0, 1'b1);

    // random back-pressure
    bp_en = 1'b1;
    for (int i = 0; i < 30; i++)
      issue(1'($urandom), rand_normal(1'b0), rand_normal(1'($urandom)), 1'b1);
    wait (exp_q.size() == 0 && !busy_o);
    bp_en = 1'b0;

    // flush mid-operation so the op never returns
    issue(1'b0, 32'h40490fdb, 32'h402df854, 1'b0);
    repeat (10) @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    assert (!busy_o && !out_valid_o)
    else begin
      $display("unit still busy after flush");
      errors++;
    end
    issue(1'b0, 32'h40490fdb, 32'h402df854, 1'b1);
    issue(1'b1, 32'h40490fdb, 32'h0, 1'b1);

    wait (exp_q.size() == 0 && !busy_o);
    repeat (3) @(negedge clk_i);
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== fdsu_lite.f ====
+incdir+verilog
verilog/fdsu_pkg.sv
verilog/fp32_div_core.sv
verilog/fp32_sqrt_core.sv
verilog/divsqrt_ctrl.sv
verilog/fdsu_lite_top.sv
sim/fdsu_lite_checker.sv
sim/fdsu_lite_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fp32 div/sqrt testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f fdsu_lite.f --top-module fdsu_lite_tb -o fdsu_lite_sim

./obj_dir/fdsu_lite_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
exit 0
